//--- hw/decoder.sv
`timescale 1ns/1ps
`include "zzcpu_defs.svh"

module decoder (
	input zzcpu_pkg::word_t if_instr_i,
	input zzcpu_pkg::word_t if_pc_i,
	input zzcpu_pkg::word_t rdata1_i,
	output zzcpu_pkg::reg_idx_t rd_idx1_o,
	output zzcpu_pkg::reg_idx_t rd_idx2_o,
	output zzcpu_pkg::alu_op_t alu_op_o,
	output logic wr_en_o,
	output zzcpu_pkg::reg_idx_t wr_reg_o,
	output zzcpu_pkg::word_t imm_o,
	output logic use_imm_o,
	output logic br_taken_o,
	output zzcpu_pkg::word_t br_target_o
);

	////////////////////////////////////////////////////////////
	// field split
	////////////////////////////////////////////////////////////

	logic [4:0] opcode;
	zzcpu_pkg::reg_idx_t rx;
	zzcpu_pkg::reg_idx_t ry;
	zzcpu_pkg::reg_idx_t rz;
	logic [7:0] imm8;
	logic [10:0] imm11;
	zzcpu_pkg::word_t imm8_zext;
	zzcpu_pkg::word_t imm8_sext;
	zzcpu_pkg::word_t imm11_sext;
	zzcpu_pkg::word_t pc_plus1;

	assign opcode = if_instr_i[15:11];
	assign rx = if_instr_i[10:8];
	assign ry = if_instr_i[7:5];
	assign rz = if_instr_i[4:2];
	assign imm8 = if_instr_i[7:0];
	assign imm11 = if_instr_i[10:0];

	// immediate extension
	assign imm8_zext = {{(`ZZ_XLEN-8){1'b0}}, imm8};
	assign imm8_sext = {{(`ZZ_XLEN-8){imm8[7]}}, imm8};
	assign imm11_sext = {{(`ZZ_XLEN-11){imm11[10]}}, imm11};

	// branches are relative to the slot after the branch
	assign pc_plus1 = if_pc_i + 1'b1;

	// every reading instruction uses rx as port 1 and ry as port 2
	assign rd_idx1_o = rx;
	assign rd_idx2_o = ry;

	////////////////////////////////////////////////////////////
	// control decode
	////////////////////////////////////////////////////////////

	always_comb begin
		// defaults give a bubble
		alu_op_o = zzcpu_pkg::alu_pass_b;
		wr_en_o = 1'b0;
		wr_reg_o = rx;
		imm_o = imm8_zext;
		use_imm_o = 1'b0;
		br_taken_o = 1'b0;
		br_target_o = pc_plus1 + imm8_sext;
		case (opcode)
			`ZZ_OP_NOP: begin
				// nothing to do
			end
			`ZZ_OP_LI: begin
				wr_en_o = 1'b1;
				use_imm_o = 1'b1;
			end
			`ZZ_OP_ADDIU: begin
				alu_op_o = zzcpu_pkg::alu_add;
				wr_en_o = 1'b1;
				imm_o = imm8_sext;
				use_imm_o = 1'b1;
			end
			`ZZ_OP_RRR: begin
				// result lands in rz
				wr_reg_o = rz;
				if (if_instr_i[1:0] == `ZZ_FN_ADDU) begin
					alu_op_o = zzcpu_pkg::alu_add;
					wr_en_o = 1'b1;
				end else if (if_instr_i[1:0] == `ZZ_FN_SUBU) begin
					alu_op_o = zzcpu_pkg::alu_sub;
					wr_en_o = 1'b1;
				end
			end
			`ZZ_OP_RR: begin
				if (if_instr_i[4:0] == `ZZ_FN_AND) begin
					alu_op_o = zzcpu_pkg::alu_and;
					wr_en_o = 1'b1;
				end else if (if_instr_i[4:0] == `ZZ_FN_OR) begin
					alu_op_o = zzcpu_pkg::alu_or;
					wr_en_o = 1'b1;
				end
			end
			`ZZ_OP_B: begin
				br_taken_o = 1'b1;
				br_target_o = pc_plus1 + imm11_sext;
			end
			`ZZ_OP_BEQZ: begin
				// rdata1 already carries the heap bypass
				br_taken_o = (rdata1_i == '0);
			end
			default: begin
				// undefined encodings fall through as nop
			end
		endcase
	end

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`include "zzcpu_defs.svh"

module execute_stage (
	input logic clk,
	input logic rst_i,
	input logic stall_i,
	input zzcpu_pkg::alu_op_t alu_op_i,
	input logic wr_en_i,
	input zzcpu_pkg::reg_idx_t wr_reg_i,
	input zzcpu_pkg::word_t imm_i,
	input logic use_imm_i,
	input zzcpu_pkg::word_t rdata1_i,
	input zzcpu_pkg::word_t rdata2_i,
	output logic wr_en_o,
	output zzcpu_pkg::reg_idx_t wr_reg_o,
	output zzcpu_pkg::word_t wr_data_o
);

	// id/ex control
	zzcpu_pkg::alu_op_t ex_alu_op;
	logic ex_wr_en;
	logic ex_use_imm;
	// id/ex payload
	zzcpu_pkg::reg_idx_t ex_wr_reg;
	zzcpu_pkg::word_t ex_imm;
	zzcpu_pkg::word_t ex_a;
	zzcpu_pkg::word_t ex_b;
	// alu operand b and result
	zzcpu_pkg::word_t op_b;
	zzcpu_pkg::word_t alu_res;

	////////////////////////////////////////////////////////////
	// id/ex register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ex_alu_op <= zzcpu_pkg::alu_pass_b;
			ex_wr_en <= 1'b0;
			ex_use_imm <= 1'b0;
		end else if (!stall_i) begin
			ex_alu_op <= alu_op_i;
			ex_wr_en <= wr_en_i;
			ex_use_imm <= use_imm_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			ex_wr_reg <= wr_reg_i;
			ex_imm <= imm_i;
			ex_a <= rdata1_i;
			ex_b <= rdata2_i;
		end
	end

	////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////

	// immediate forms replace ry
	assign op_b = ex_use_imm ? ex_imm : ex_b;

	always_comb begin
		case (ex_alu_op)
			zzcpu_pkg::alu_add: alu_res = ex_a + op_b;
			zzcpu_pkg::alu_sub: alu_res = ex_a - op_b;
			zzcpu_pkg::alu_and: alu_res = ex_a & op_b;
			zzcpu_pkg::alu_or: alu_res = ex_a | op_b;
			default: alu_res = op_b;
		endcase
	end

	// write-back port held off while the pipe is frozen
	assign wr_en_o = ex_wr_en & ~stall_i;
	assign wr_reg_o = ex_wr_reg;
	assign wr_data_o = alu_res;

	// a real write-back carries a resolved result
	a_wb_data_known: assert property (@(posedge clk) disable iff (rst_i)
		wr_en_o |-> !$isunknown(wr_data_o));

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`include "zzcpu_defs.svh"

module fetch_stage (
	input logic clk,
	input logic rst_i,
	input logic stall_i,
	input logic br_taken_i,
	input zzcpu_pkg::word_t br_target_i,
	output zzcpu_pkg::word_t imem_addr_o,
	input zzcpu_pkg::word_t imem_data_i,
	output zzcpu_pkg::word_t if_pc_o,
	output zzcpu_pkg::word_t if_instr_o
);

	// current fetch address
	zzcpu_pkg::word_t pc_q;
	// if/id register
	zzcpu_pkg::word_t if_pc_q;
	zzcpu_pkg::word_t if_instr_q;

	////////////////////////////////////////////////////////////
	// program counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q <= `ZZ_RESET_PC;
		end else if (!stall_i) begin
			// redirect wins over sequential fetch
			if (br_taken_i) begin
				pc_q <= br_target_i;
			end else begin
				pc_q <= pc_q + 1'b1;
			end
		end
	end

	// async sram port, data comes back same cycle
	assign imem_addr_o = pc_q;

	////////////////////////////////////////////////////////////
	// if/id register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			if_instr_q <= `ZZ_NOP_INSTR;
			if_pc_q <= `ZZ_RESET_PC;
		end else if (!stall_i) begin
			// squash the one sequential slot behind a taken branch
			if (br_taken_i) begin
				if_instr_q <= `ZZ_NOP_INSTR;
			end else begin
				if_instr_q <= imem_data_i;
			end
			if_pc_q <= pc_q;
		end
	end

	assign if_pc_o = if_pc_q;
	assign if_instr_o = if_instr_q;

	// branch target comes from decode, must stay resolved
	a_pc_known: assert property (@(posedge clk) disable iff (rst_i) !$isunknown(pc_q));

endmodule

//--- hw/register_heap.sv
`timescale 1ns/1ps
`include "zzcpu_defs.svh"

module register_heap (
	input logic clk,
	input logic rst_i,
	input zzcpu_pkg::reg_idx_t rd_idx1_i,
	input zzcpu_pkg::reg_idx_t rd_idx2_i,
	input logic wr_en_i,
	input zzcpu_pkg::reg_idx_t wr_reg_i,
	input zzcpu_pkg::word_t wr_data_i,
	output zzcpu_pkg::word_t rdata1_o,
	output zzcpu_pkg::word_t rdata2_o
);

	// general registers r0..r7
	zzcpu_pkg::word_t regs_q [`ZZ_NREG];

	////////////////////////////////////////////////////////////
	// write port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < `ZZ_NREG; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en_i) begin
			regs_q[wr_reg_i] <= wr_data_i;
		end
	end

	////////////////////////////////////////////////////////////
	// read ports with write-through
	////////////////////////////////////////////////////////////

	// a write in flight this cycle shows up on the read
	// so the next instruction sees it without a stall
	always_comb begin
		if (wr_en_i && (wr_reg_i == rd_idx1_i)) begin
			rdata1_o = wr_data_i;
		end else begin
			rdata1_o = regs_q[rd_idx1_i];
		end
	end

	always_comb begin
		if (wr_en_i && (wr_reg_i == rd_idx2_i)) begin
			rdata2_o = wr_data_i;
		end else begin
			rdata2_o = regs_q[rd_idx2_i];
		end
	end

	// execute must hand over a resolved destination
	a_wr_reg_known: assert property (@(posedge clk) disable iff (rst_i)
		wr_en_i |-> !$isunknown(wr_reg_i));

endmodule

//--- hw/zzcpu.sv
`timescale 1ns/1ps
`include "zzcpu_defs.svh"

module zzcpu (
	input logic clk,
	input logic rst_i,
	input logic stall_i,
	// program memory, async read
	output zzcpu_pkg::word_t imem_addr_o,
	input zzcpu_pkg::word_t imem_data_i,
	// write-back trace
	output logic wb_en_o,
	output zzcpu_pkg::reg_idx_t wb_reg_o,
	output zzcpu_pkg::word_t wb_data_o
);

	////////////////////////////////////////////////////////////
	// stage wires
	////////////////////////////////////////////////////////////

	// if/id to decode
	zzcpu_pkg::word_t if_pc;
	zzcpu_pkg::word_t if_instr;
	// decode back to fetch
	logic br_taken;
	zzcpu_pkg::word_t br_target;
	// decode and heap read side
	zzcpu_pkg::reg_idx_t rd_idx1;
	zzcpu_pkg::reg_idx_t rd_idx2;
	zzcpu_pkg::word_t rdata1;
	zzcpu_pkg::word_t rdata2;
	// decode to execute
	zzcpu_pkg::alu_op_t id_alu_op;
	logic id_wr_en;
	zzcpu_pkg::reg_idx_t id_wr_reg;
	zzcpu_pkg::word_t id_imm;
	logic id_use_imm;
	// execute write port
	logic wr_en;
	zzcpu_pkg::reg_idx_t wr_reg;
	zzcpu_pkg::word_t wr_data;

	fetch_stage u_fetch (
		.clk(clk),
		.rst_i(rst_i),
		.stall_i(stall_i),
		.br_taken_i(br_taken),
		.br_target_i(br_target),
		.imem_addr_o(imem_addr_o),
		.imem_data_i(imem_data_i),
		.if_pc_o(if_pc),
		.if_instr_o(if_instr)
	);

	// decode and heap look at the same instruction in parallel
	decoder u_decoder (
		.if_instr_i(if_instr),
		.if_pc_i(if_pc),
		.rdata1_i(rdata1),
		.rd_idx1_o(rd_idx1),
		.rd_idx2_o(rd_idx2),
		.alu_op_o(id_alu_op),
		.wr_en_o(id_wr_en),
		.wr_reg_o(id_wr_reg),
		.imm_o(id_imm),
		.use_imm_o(id_use_imm),
		.br_taken_o(br_taken),
		.br_target_o(br_target)
	);

	register_heap u_regheap (
		.clk(clk),
		.rst_i(rst_i),
		.rd_idx1_i(rd_idx1),
		.rd_idx2_i(rd_idx2),
		.wr_en_i(wr_en),
		.wr_reg_i(wr_reg),
		.wr_data_i(wr_data),
		.rdata1_o(rdata1),
		.rdata2_o(rdata2)
	);

	execute_stage u_execute (
		.clk(clk),
		.rst_i(rst_i),
		.stall_i(stall_i),
		.alu_op_i(id_alu_op),
		.wr_en_i(id_wr_en),
		.wr_reg_i(id_wr_reg),
		.imm_i(id_imm),
		.use_imm_i(id_use_imm),
		.rdata1_i(rdata1),
		.rdata2_i(rdata2),
		.wr_en_o(wr_en),
		.wr_reg_o(wr_reg),
		.wr_data_o(wr_data)
	);

	// trace mirrors the heap write port
	assign wb_en_o = wr_en;
	assign wb_reg_o = wr_reg;
	assign wb_data_o = wr_data;

endmodule

//--- hw/zzcpu_pkg.sv
`include "zzcpu_defs.svh"

// shared core types
package zzcpu_pkg;

	// one machine word, data or pc
	typedef logic [`ZZ_XLEN-1:0] word_t;

	// register number, 3 bits for 8 registers
	typedef logic [$clog2(`ZZ_NREG)-1:0] reg_idx_t;

	////////////////////////////////////////////////////////////
	// alu operations
	////////////////////////////////////////////////////////////

	// pass_b forwards operand b, used by li
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_pass_b
	} alu_op_t;

endpackage

//--- include/zzcpu_defs.svh
`ifndef ZZCPU_DEFS_SVH
`define ZZCPU_DEFS_SVH

////////////////////////////////////////////////////////////
// sizes
////////////////////////////////////////////////////////////

// data and pc width
`define ZZ_XLEN 16
// number of general registers
`define ZZ_NREG 8
// pc after reset
`define ZZ_RESET_PC 16'h0000

////////////////////////////////////////////////////////////
// major opcodes, instr[15:11]
////////////////////////////////////////////////////////////

`define ZZ_OP_NOP 5'b00001
`define ZZ_OP_B 5'b00010
`define ZZ_OP_BEQZ 5'b00100
`define ZZ_OP_ADDIU 5'b01001
`define ZZ_OP_LI 5'b01101
// three-register group, function in instr[1:0]
`define ZZ_OP_RRR 5'b11100
// two-register group, function in instr[4:0]
`define ZZ_OP_RR 5'b11101

// function fields
`define ZZ_FN_ADDU 2'b01
`define ZZ_FN_SUBU 2'b11
`define ZZ_FN_AND 5'b01100
`define ZZ_FN_OR 5'b01101

// bubble loaded into if/id on reset and flush
`define ZZ_NOP_INSTR 16'h0800

`endif

//--- tests/zzcpu_tb.sv
`timescale 1ns/1ps
`include "zzcpu_defs.svh"

module zzcpu_tb;

	localparam int CLK_PERIOD = 100;
	localparam int PROG_LEN = 16;
	localparam int EXP_LEN = 10;
	// per-row wait bound with slack for random stalls
	localparam int WB_TIMEOUT = 24;
	localparam int IDLE_WINDOW = 16;

	logic clk = 1'b0;
	logic rst_i = 1'b1;
	logic stall_i = 1'b0;
	logic [15:0] imem_addr_o;
	logic [15:0] imem_data_i;
	logic wb_en_o;
	logic [2:0] wb_reg_o;
	logic [15:0] wb_data_o;

	// program and expected write-back tables
	logic [15:0] prog [PROG_LEN];
	string exp_name [EXP_LEN];
	logic [15:0] exp_reg [EXP_LEN];
	logic [15:0] exp_data [EXP_LEN];

	integer seed = 44;
	int errors = 0;
	int checked = 0;
	int row;
	int wait_cycles;
	logic seen;
	logic aborted = 1'b0;

	always #(CLK_PERIOD/2) clk = ~clk;

	// back-pressure about one cycle in four
	always @(negedge clk) begin
		stall_i <= (($random(seed) & 3) == 0);
	end

	// async instruction rom returning nop past the end
	assign imem_data_i = (imem_addr_o < PROG_LEN) ? prog[imem_addr_o] : `ZZ_NOP_INSTR;

	zzcpu u_zzcpu (
		.clk(clk),
		.rst_i(rst_i),
		.stall_i(stall_i),
		.imem_addr_o(imem_addr_o),
		.imem_data_i(imem_data_i),
		.wb_en_o(wb_en_o),
		.wb_reg_o(wb_reg_o),
		.wb_data_o(wb_data_o)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// quarter period before the rising edge when outputs are settled
	task automatic next_sample();
		@(negedge clk);
		#(CLK_PERIOD/4);
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic set_expect(input int idx, input string name, input logic [15:0] rnum,
		input logic [15:0] data);
		exp_name[idx] = name;
		exp_reg[idx] = rnum;
		exp_data[idx] = data;
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		for (int i = 0; i < PROG_LEN; i++) begin
			prog[i] = `ZZ_NOP_INSTR;
		end
		prog[0] = 16'h6905;   // li r1, 0x05
		prog[1] = 16'h6A03;   // li r2, 0x03
		prog[2] = 16'h49FF;   // addiu r1, -1
		prog[3] = 16'hE14D;   // addu r3 = r1 + r2
		prog[4] = 16'hE353;   // subu r4 = r3 - r2
		prog[5] = 16'hEC4D;   // or r4, r2
		prog[6] = 16'hEC2C;   // and r4, r1
		prog[7] = 16'h1001;   // b +1
		prog[8] = 16'h6DEE;   // li r5 squashed by the branch
		prog[9] = 16'h6E00;   // li r6, 0
		prog[10] = 16'h2601;  // beqz r6, +1 is taken
		prog[11] = 16'h6DBB;  // li r5 squashed by the beqz
		prog[12] = 16'h2101;  // beqz r1, +1 falls through
		prog[13] = 16'h6F80;  // li r7, 0x80 zero-extended
		prog[14] = 16'h4F80;  // addiu r7, -128 wraps to zero

		// one row per expected write-back, in order
		set_expect(0, "li_r1", 1, 16'h0005);
		set_expect(1, "li_r2", 2, 16'h0003);
		set_expect(2, "addiu_neg", 1, 16'h0004);
		set_expect(3, "addu_bypass", 3, 16'h0007);
		set_expect(4, "subu_bypass", 4, 16'h0004);
		set_expect(5, "or_bypass", 4, 16'h0007);
		set_expect(6, "and_bypass", 4, 16'h0004);
		set_expect(7, "li_after_b", 6, 16'h0000);
		set_expect(8, "li_beqz_fall", 7, 16'h0080);
		set_expect(9, "addiu_wrap", 7, 16'h0000);

		// trace must stay quiet in the reset window
		repeat (4) begin
			next_sample();
			if (wb_en_o !== 1'b0) begin
				errors++;
				$display("write-back enable was not low during reset");
			end
		end
		@(negedge clk);
		rst_i = 1'b0;

		row = 0;
		while (row < EXP_LEN && !aborted) begin
			wait_cycles = 0;
			seen = 1'b0;
			while (!seen && wait_cycles < WB_TIMEOUT) begin
				next_sample();
				wait_cycles++;
				if (wb_en_o === 1'b1) begin
					seen = 1'b1;
				end
			end
			if (!seen) begin
				errors++;
				$display("timeout: write-back for row %0d (%s) never arrived", row, exp_name[row]);
				aborted = 1'b1;
			end else begin
				check_value({exp_name[row], "_reg"}, exp_reg[row], {13'd0, wb_reg_o});
				check_value({exp_name[row], "_data"}, exp_data[row], wb_data_o);
				checked++;
			end
			row++;
		end

		// program tail is all nops
		if (!aborted) begin
			for (int i = 0; i < IDLE_WINDOW; i++) begin
				next_sample();
				if (wb_en_o !== 1'b0) begin
					errors++;
					$display("unexpected write-back to r%0d with data %h after the program ended",
						wb_reg_o, wb_data_o);
				end
			end
		end

		$display("%0d errors, %0d of %0d write-backs checked", errors, checked, EXP_LEN);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
hw/zzcpu_pkg.sv
hw/fetch_stage.sv
hw/decoder.sv
hw/register_heap.sv
hw/execute_stage.sv
hw/zzcpu.sv
tests/zzcpu_tb.sv
